// ==== design/csr_pkg.sv ====
package csr_pkg;

  // basic widths
  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;
  typedef logic [1:0]  csr_op_t;

  // operation encoding
  localparam csr_op_t CSR_OP_NONE  = 2'b00;
  localparam csr_op_t CSR_OP_WRITE = 2'b01;
  localparam csr_op_t CSR_OP_SET   = 2'b10;
  localparam csr_op_t CSR_OP_CLEAR = 2'b11;

  ////////////////////
  // address map
  ////////////////////
  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MHARTID   = 12'hF14;
  localparam csr_addr_t CSR_PCCR_BASE = 12'h780;
  localparam csr_addr_t CSR_PCCR_ALL  = 12'h79F;
  localparam csr_addr_t CSR_PCER      = 12'h7A0;
  localparam csr_addr_t CSR_PCMR      = 12'h7A1;

  // mstatus bit positions
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;

  // fixed mtvec mode field, reads as vectored
  localparam logic [1:0] MTVEC_MODE = 2'b01;

  typedef struct packed {
    logic       irq;
    logic [4:0] code;
  } mcause_t;

  typedef struct packed {
    logic mie;
    logic mpie;
  } mstatus_t;

  // trap controls from the core, single-cycle pulses
  typedef struct packed {
    logic      save_cause;
    logic      save_if;
    logic      save_id;
    csr_data_t pc_if;
    csr_data_t pc_id;
    mcause_t   cause;
    logic      restore_mret;
  } trap_req_t;

endpackage

// ==== design/perf_pkg.sv ====
package perf_pkg;

  // built-in counters, one per event line
  localparam int N_BASE_EVENTS = 8;

  ////////////////////
  // event indices
  ////////////////////
  localparam int EV_CYCLE     = 0;
  localparam int EV_INSTR     = 1;
  localparam int EV_LD_STALL  = 2;
  localparam int EV_JUMP      = 3;
  localparam int EV_BRANCH    = 4;
  localparam int EV_BRANCH_TK = 5;
  localparam int EV_LOAD      = 6;
  localparam int EV_STORE     = 7;

  // raw event levels from the pipeline
  typedef struct packed {
    logic id_valid;
    logic is_decoding;
    logic ld_stall;
    logic jump;
    logic branch;
    logic branch_taken;
    logic mem_load;
    logic mem_store;
  } perf_events_t;

endpackage

// ==== design/machine_csrs.sv ====
`timescale 1ns/1ps

module machine_csrs import csr_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  input  csr_addr_t addr_i,
  input  csr_data_t wdata_i,
  input  logic      we_i,

  input  trap_req_t trap_i,

  output csr_data_t rdata_o,
  output csr_data_t mepc_o,
  output logic      m_irq_enable_o
);

  mstatus_t  mstatus_q, mstatus_d;
  csr_data_t mepc_q, mepc_d;
  mcause_t   mcause_q, mcause_d;
  csr_data_t exception_pc;

  ////////////////////
  // read port
  ////////////////////
  always_comb begin
    rdata_o = '0;
    case (addr_i)
      CSR_MSTATUS: begin
        // MPP is hardwired to machine mode
        rdata_o[12:11]            = 2'b11;
        rdata_o[MSTATUS_MPIE_BIT] = mstatus_q.mpie;
        rdata_o[MSTATUS_MIE_BIT]  = mstatus_q.mie;
      end
      CSR_MEPC: begin
        rdata_o = mepc_q;
      end
      CSR_MCAUSE: begin
        rdata_o = {mcause_q.irq, 26'b0, mcause_q.code};
      end
      default: begin
        rdata_o = '0;
      end
    endcase
  end

  // pc to save on a trap
  always_comb begin
    exception_pc = trap_i.pc_id;
    if (trap_i.save_if) begin
      exception_pc = trap_i.pc_if;
    end
  end

  ////////////////////
  // next state
  ////////////////////
  always_comb begin
    mstatus_d = mstatus_q;
    mepc_d    = mepc_q;
    mcause_d  = mcause_q;

    if (we_i) begin
      case (addr_i)
        CSR_MSTATUS: begin
          mstatus_d.mie  = wdata_i[MSTATUS_MIE_BIT];
          mstatus_d.mpie = wdata_i[MSTATUS_MPIE_BIT];
        end
        CSR_MEPC: begin
          mepc_d = wdata_i;
        end
        CSR_MCAUSE: begin
          mcause_d.irq  = wdata_i[31];
          mcause_d.code = wdata_i[4:0];
        end
        default: begin
        end
      endcase
    end

    // trap controls override any CSR write
    if (trap_i.save_cause) begin
      mepc_d         = exception_pc;
      mcause_d       = trap_i.cause;
      mstatus_d.mpie = mstatus_q.mie;
      mstatus_d.mie  = 1'b0;
    end else if (trap_i.restore_mret) begin
      mstatus_d.mie  = mstatus_q.mpie;
      mstatus_d.mpie = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      mstatus_q <= mstatus_d;
      mepc_q    <= mepc_d;
      mcause_q  <= mcause_d;
    end
  end

  assign mepc_o         = mepc_q;
  assign m_irq_enable_o = mstatus_q.mie;

endmodule

// ==== design/perf_counters.sv ====
`timescale 1ns/1ps

module perf_counters import csr_pkg::*, perf_pkg::*; #(
  parameter int N_EXT_EVENTS = 2
) (
  input  logic                    clk,
  input  logic                    rst_n,

  input  csr_addr_t               addr_i,
  input  csr_data_t               wdata_i,
  input  logic                    we_i,

  input  perf_events_t            events_i,
  input  logic [N_EXT_EVENTS-1:0] ext_events_i,

  output csr_data_t               rdata_o
);

  localparam int N_CNT    = N_BASE_EVENTS + N_EXT_EVENTS;
  localparam int PCMR_EN  = 0;
  localparam int PCMR_SAT = 1;

  logic             id_valid_q;
  logic [N_CNT-1:0] ev_line;
  logic [N_CNT-1:0] inc_d, inc_q;
  logic [N_CNT-1:0] pcer_q, pcer_d;
  logic [1:0]       pcmr_q, pcmr_d;
  csr_data_t        cnt_q [N_CNT];
  csr_data_t        cnt_d [N_CNT];

  logic       is_pccr;
  logic       pccr_all;
  logic [4:0] pccr_idx;

  ////////////////////
  // event lines
  ////////////////////
  assign ev_line[EV_CYCLE]     = 1'b1;
  assign ev_line[EV_INSTR]     = events_i.id_valid & events_i.is_decoding;
  assign ev_line[EV_LD_STALL]  = events_i.ld_stall & id_valid_q;
  assign ev_line[EV_JUMP]      = events_i.jump & id_valid_q;
  assign ev_line[EV_BRANCH]    = events_i.branch & id_valid_q;
  assign ev_line[EV_BRANCH_TK] = events_i.branch & events_i.branch_taken & id_valid_q;
  assign ev_line[EV_LOAD]      = events_i.mem_load;
  assign ev_line[EV_STORE]     = events_i.mem_store;

  // external events sit right after the built-in ones
  for (genvar g = 0; g < N_EXT_EVENTS; g++) begin : g_ext
    assign ev_line[N_BASE_EVENTS+g] = ext_events_i[g];
  end

  // gated by event enable and global enable
  assign inc_d = ev_line & pcer_q & {N_CNT{pcmr_q[PCMR_EN]}};

  ////////////////////
  // address decode
  ////////////////////
  assign is_pccr  = (addr_i[11:5] == CSR_PCCR_BASE[11:5]);
  assign pccr_all = (addr_i == CSR_PCCR_ALL);
  assign pccr_idx = addr_i[4:0];

  always_comb begin
    rdata_o = '0;
    if (addr_i == CSR_PCER) begin
      rdata_o[N_CNT-1:0] = pcer_q;
    end else if (addr_i == CSR_PCMR) begin
      rdata_o[1:0] = pcmr_q;
    end else if (is_pccr && !pccr_all) begin
      // indices past the last counter fall through as zero
      for (int i = 0; i < N_CNT; i++) begin
        if (pccr_idx == 5'(i)) begin
          rdata_o = cnt_q[i];
        end
      end
    end
  end

  ////////////////////
  // counter update
  ////////////////////
  always_comb begin
    for (int i = 0; i < N_CNT; i++) begin
      cnt_d[i] = cnt_q[i];
      if (inc_q[i] && ((cnt_q[i] != '1) || !pcmr_q[PCMR_SAT])) begin
        cnt_d[i] = cnt_q[i] + 32'd1;
      end
      // a CSR write wins over a pending increment
      if (we_i && is_pccr && (pccr_all || pccr_idx == 5'(i))) begin
        cnt_d[i] = wdata_i;
      end
    end
  end

  always_comb begin
    pcer_d = pcer_q;
    pcmr_d = pcmr_q;
    if (we_i && addr_i == CSR_PCER) begin
      pcer_d = wdata_i[N_CNT-1:0];
    end
    if (we_i && addr_i == CSR_PCMR) begin
      pcmr_d = wdata_i[1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
      pcer_q     <= '0;
      // enabled and saturating out of reset
      pcmr_q     <= 2'b11;
      for (int i = 0; i < N_CNT; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      id_valid_q <= events_i.id_valid;
      inc_q      <= inc_d;
      pcer_q     <= pcer_d;
      pcmr_q     <= pcmr_d;
      for (int i = 0; i < N_CNT; i++) begin
        cnt_q[i] <= cnt_d[i];
      end
    end
  end

endmodule

// ==== design/csr_file.sv ====
`timescale 1ns/1ps

module csr_file import csr_pkg::*, perf_pkg::*; #(
  parameter int N_EXT_EVENTS = 2
) (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic [3:0]              core_id_i,
  input  logic [5:0]              cluster_id_i,
  input  logic [30:0]             boot_addr_i,

  // CSR port from the core
  input  logic                    csr_access_i,
  input  csr_addr_t               csr_addr_i,
  input  csr_op_t                 csr_op_i,
  input  csr_data_t               csr_wdata_i,
  output csr_data_t               csr_rdata_o,

  input  trap_req_t               trap_i,

  input  perf_events_t            events_i,
  input  logic [N_EXT_EVENTS-1:0] ext_events_i,

  output csr_data_t               mepc_o,
  output logic                    m_irq_enable_o
);

  csr_data_t wdata_res;
  logic      we;
  csr_data_t top_rdata;
  csr_data_t mcsr_rdata;
  csr_data_t perf_rdata;
  csr_data_t mhartid;
  csr_data_t mtvec;

  ////////////////////
  // operation resolve
  ////////////////////
  assign we = csr_access_i && (csr_op_i != CSR_OP_NONE);

  // set and clear work on the combined read value
  always_comb begin
    case (csr_op_i)
      CSR_OP_SET:   wdata_res = csr_wdata_i | csr_rdata_o;
      CSR_OP_CLEAR: wdata_res = csr_rdata_o & ~csr_wdata_i;
      default:      wdata_res = csr_wdata_i;
    endcase
  end

  ////////////////////
  // read-only ids
  ////////////////////
  assign mhartid = {21'b0, cluster_id_i, 1'b0, core_id_i};
  assign mtvec   = {boot_addr_i[30:7], 6'b0, MTVEC_MODE};

  always_comb begin
    case (csr_addr_i)
      CSR_MHARTID: top_rdata = mhartid;
      CSR_MTVEC:   top_rdata = mtvec;
      default:     top_rdata = '0;
    endcase
  end

  // children return zero outside their own range
  assign csr_rdata_o = top_rdata | mcsr_rdata | perf_rdata;

  machine_csrs u_machine_csrs (
    .clk            (clk),
    .rst_n          (rst_n),
    .addr_i         (csr_addr_i),
    .wdata_i        (wdata_res),
    .we_i           (we),
    .trap_i         (trap_i),
    .rdata_o        (mcsr_rdata),
    .mepc_o         (mepc_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  perf_counters #(
    .N_EXT_EVENTS (N_EXT_EVENTS)
  ) u_perf_counters (
    .clk          (clk),
    .rst_n        (rst_n),
    .addr_i       (csr_addr_i),
    .wdata_i      (wdata_res),
    .we_i         (we),
    .events_i     (events_i),
    .ext_events_i (ext_events_i),
    .rdata_o      (perf_rdata)
  );

endmodule

// ==== bench/csr_vectors.svh ====
`ifndef CSR_VECTORS_SVH
`define CSR_VECTORS_SVH

// counter addresses and enable masks used by the table
localparam csr_addr_t LOAD_CNT  = CSR_PCCR_BASE + 12'(EV_LOAD);
localparam csr_addr_t STORE_CNT = CSR_PCCR_BASE + 12'(EV_STORE);
localparam csr_addr_t EXT0_CNT  = CSR_PCCR_BASE + 12'(N_BASE_EVENTS);
localparam csr_data_t LOAD_EN   = 32'd1 << EV_LOAD;
localparam csr_data_t EXT0_EN   = 32'd1 << N_BASE_EVENTS;

// trap pulses
localparam trap_req_t TRAP_IF = '{save_cause: 1'b1, save_if: 1'b1, pc_if: 32'h2000,
                                  pc_id: 32'h3000, cause: 6'h0B, default: '0};
localparam trap_req_t TRAP_ID = '{save_cause: 1'b1, save_id: 1'b1, pc_if: 32'h2000,
                                  pc_id: 32'h4400, cause: 6'h27, default: '0};
localparam trap_req_t MRET    = '{restore_mret: 1'b1, default: '0};

// loads and stores pulse together while only loads are enabled
localparam perf_events_t MEM_EV = '{mem_load: 1'b1, mem_store: 1'b1, default: 1'b0};

typedef struct {
  string                   name;
  csr_op_t                 op;
  csr_addr_t               addr;
  csr_data_t               wdata;
  trap_req_t               trap;
  perf_events_t            ev;
  logic [N_EXT_EVENTS-1:0] ext;
  int                      ev_cycles;
  int                      idle;
  csr_data_t               expected;
  logic                    irq;
} vector_t;

vector_t vectors[$];

task automatic add_row(input string name, input csr_op_t op, input csr_addr_t addr,
                       input csr_data_t wdata, input trap_req_t trap, input perf_events_t ev,
                       input logic [N_EXT_EVENTS-1:0] ext, input int ev_cycles, input int idle,
                       input csr_data_t expected, input logic irq);
  vectors.push_back('{name, op, addr, wdata, trap, ev, ext, ev_cycles, idle, expected, irq});
endtask

// name, op, addr, wdata, trap, events, ext events, event cycles, idle, expected, irq
task automatic load_vectors();
  add_row("reset_mstatus", CSR_OP_NONE, CSR_MSTATUS, '0, '0, '0, '0, 0, 0, 32'h1800, 1'b0);
  add_row("reset_pcmr", CSR_OP_NONE, CSR_PCMR, '0, '0, '0, '0, 0, 0, 32'h3, 1'b0);
  add_row("reset_mhartid", CSR_OP_NONE, CSR_MHARTID, '0, '0, '0, '0, 0, 0,
          (32'(CLUSTER_ID) << 5) | 32'(CORE_ID), 1'b0);
  // boot address bits 30:7 move up one place, low byte holds the mode
  add_row("reset_mtvec", CSR_OP_NONE, CSR_MTVEC, '0, '0, '0, '0, 0, 0,
          ((32'(BOOT_ADDR) << 1) & 32'hFFFF_FF00) | 32'h1, 1'b0);
  add_row("mepc_write", CSR_OP_WRITE, CSR_MEPC, 32'h1234, '0, '0, '0, 0, 0, 32'h1234, 1'b0);
  add_row("mepc_set", CSR_OP_SET, CSR_MEPC, '0, '0, '0, '0, 0, 0, '0, 1'b0);
  add_row("mepc_clear", CSR_OP_CLEAR, CSR_MEPC, '0, '0, '0, '0, 0, 0, '0, 1'b0);
  add_row("mie_on", CSR_OP_WRITE, CSR_MSTATUS, 32'h8, '0, '0, '0, 0, 0, 32'h1808, 1'b1);
  add_row("trap_if_pc", CSR_OP_NONE, CSR_MEPC, '0, TRAP_IF, '0, '0, 0, 0, 32'h2000, 1'b0);
  add_row("trap_if_cause", CSR_OP_NONE, CSR_MCAUSE, '0, '0, '0, '0, 0, 0, 32'hB, 1'b0);
  add_row("trap_mstatus", CSR_OP_NONE, CSR_MSTATUS, '0, '0, '0, '0, 0, 0, 32'h1880, 1'b0);
  add_row("mret", CSR_OP_NONE, CSR_MSTATUS, '0, MRET, '0, '0, 0, 0, 32'h1888, 1'b1);
  // trap and mepc write in one cycle
  add_row("trap_over_write", CSR_OP_WRITE, CSR_MEPC, 32'hDEAD_BEEF, TRAP_ID, '0, '0, 0, 0,
          32'h4400, 1'b0);
  add_row("trap_id_cause", CSR_OP_NONE, CSR_MCAUSE, '0, '0, '0, '0, 0, 0, 32'h8000_0007, 1'b0);
  add_row("pcer_load", CSR_OP_WRITE, CSR_PCER, LOAD_EN, '0, '0, '0, 0, 0, LOAD_EN, 1'b0);
  add_row("load_count", CSR_OP_NONE, LOAD_CNT, '0, '0, MEM_EV, '0, 5, 2, 32'd5, 1'b0);
  add_row("store_count", CSR_OP_NONE, STORE_CNT, '0, '0, '0, '0, 0, 0, 32'd0, 1'b0);
  add_row("pcer_ext", CSR_OP_WRITE, CSR_PCER, EXT0_EN, '0, '0, '0, 0, 0, EXT0_EN, 1'b0);
  add_row("ext_count", CSR_OP_NONE, EXT0_CNT, '0, '0, '0, 2'b01, 3, 2, 32'd3, 1'b0);
  add_row("cycle_ones", CSR_OP_WRITE, CSR_PCCR_BASE, '1, '0, '0, '0, 0, 0, '1, 1'b0);
  add_row("pcer_cycle", CSR_OP_WRITE, CSR_PCER, 32'h1, '0, '0, '0, 0, 0, 32'h1, 1'b0);
  add_row("cycle_sat", CSR_OP_NONE, CSR_PCCR_BASE, '0, '0, '0, '0, 0, 3, '1, 1'b0);
  add_row("pcmr_wrap", CSR_OP_WRITE, CSR_PCMR, 32'h1, '0, '0, '0, 0, 0, 32'h1, 1'b0);
  // wraps to zero, then three more increments before the read
  add_row("cycle_wrap", CSR_OP_NONE, CSR_PCCR_BASE, '0, '0, '0, '0, 0, 2, 32'd3, 1'b0);
endtask

`endif

// ==== bench/csr_tb.sv ====
`timescale 1ns/1ps

module csr_tb import csr_pkg::*, perf_pkg::*; ();

  localparam int          N_EXT_EVENTS = 2;
  localparam logic [3:0]  CORE_ID      = 4'h5;
  localparam logic [5:0]  CLUSTER_ID   = 6'h2A;
  localparam logic [30:0] BOOT_ADDR    = 31'h1C00_0080;
  localparam int          MARGIN       = 20;

  logic                    clk;
  logic                    rst_n;
  logic                    csr_access_i;
  csr_addr_t               csr_addr_i;
  csr_op_t                 csr_op_i;
  csr_data_t               csr_wdata_i;
  csr_data_t               csr_rdata_o;
  trap_req_t               trap_i;
  perf_events_t            events_i;
  logic [N_EXT_EVENTS-1:0] ext_events_i;
  csr_data_t               mepc_o;
  logic                    m_irq_enable_o;

  int        seed = 32'h8d25;
  int        errors = 0;
  int        checks = 0;
  int        cycles = 0;
  int        limit = 0;
  csr_data_t prev_exp = '0;

`include "csr_vectors.svh"

  csr_file #(
    .N_EXT_EVENTS (N_EXT_EVENTS)
  ) dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .core_id_i      (CORE_ID),
    .cluster_id_i   (CLUSTER_ID),
    .boot_addr_i    (BOOT_ADDR),
    .csr_access_i   (csr_access_i),
    .csr_addr_i     (csr_addr_i),
    .csr_op_i       (csr_op_i),
    .csr_wdata_i    (csr_wdata_i),
    .csr_rdata_o    (csr_rdata_o),
    .trap_i         (trap_i),
    .events_i       (events_i),
    .ext_events_i   (ext_events_i),
    .mepc_o         (mepc_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic drop_controls(input bit with_events);
    csr_access_i <= 1'b0;
    csr_op_i     <= CSR_OP_NONE;
    trap_i       <= '0;
    if (with_events) begin
      events_i     <= '0;
      ext_events_i <= '0;
    end
  endtask

  ////////////////////
  // one table row
  ////////////////////
  task automatic apply_vector(input vector_t v);
    csr_data_t wdata;
    csr_data_t expected;
    wdata    = v.wdata;
    expected = v.expected;
    // set and clear act on the value the previous row read back
    if (v.op == CSR_OP_SET || v.op == CSR_OP_CLEAR) begin
      wdata    = $random(seed);
      expected = (v.op == CSR_OP_SET) ? (prev_exp | wdata) : (prev_exp & ~wdata);
    end
    @(posedge clk);
    csr_access_i <= (v.op != CSR_OP_NONE);
    csr_op_i     <= v.op;
    csr_addr_i   <= v.addr;
    csr_wdata_i  <= wdata;
    trap_i       <= v.trap;
    if (v.ev_cycles > 0) begin
      events_i     <= v.ev;
      ext_events_i <= v.ext;
    end
    // events stay up, op and trap last one cycle
    for (int i = 1; i < v.ev_cycles; i++) begin
      @(posedge clk);
      drop_controls(1'b0);
    end
    @(posedge clk);
    drop_controls(1'b1);
    repeat (v.idle) @(posedge clk);
    // read cycle, sampled mid-cycle
    @(negedge clk);
    checks += 2;
    if (csr_rdata_o !== expected) begin
      errors++;
      $display("[ERROR] %s: rdata expected %h, actual %h", v.name, expected, csr_rdata_o);
    end
    if (m_irq_enable_o !== v.irq) begin
      errors++;
      $display("[ERROR] %s: irq enable expected %b, actual %b", v.name, v.irq, m_irq_enable_o);
    end
    if (v.addr == CSR_MEPC) begin
      checks++;
      if (mepc_o !== expected) begin
        errors++;
        $display("[ERROR] %s: mepc_o expected %h, actual %h", v.name, expected, mepc_o);
      end
    end
    prev_exp = expected;
  endtask

  initial begin
    rst_n        <= 1'b0;
    csr_access_i <= 1'b0;
    csr_addr_i   <= '0;
    csr_op_i     <= CSR_OP_NONE;
    csr_wdata_i  <= '0;
    trap_i       <= '0;
    events_i     <= '0;
    ext_events_i <= '0;
    load_vectors();
    // hold cycles, idle cycles and the read cycle of each row
    limit = 10 + MARGIN;
    foreach (vectors[i]) begin
      limit += ((vectors[i].ev_cycles > 1) ? vectors[i].ev_cycles : 1) + vectors[i].idle + 1;
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    foreach (vectors[i]) begin
      apply_vector(vectors[i]);
    end
    $display("rows: %0d, checks: %0d, errors: %0d", vectors.size(), checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+bench
design/csr_pkg.sv
design/perf_pkg.sv
design/machine_csrs.sv
design/perf_counters.sv
design/csr_file.sv
bench/csr_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --timescale 1ns/1ps --top-module csr_tb -f filelist.f -o csr_sim
out=$(./obj_dir/csr_sim)
echo "$out"

if echo "$out" | grep -q "^RESULT: PASS$"; then
  exit 0
else
  exit 1
fi
